// File: tiny_cfg.svh
`ifndef TINY_CFG_SVH
`define TINY_CFG_SVH

// Depth of the word-addressed memory. Addresses wrap at this size.
`define TINY_MEM_WORDS 256

// Cycles between the rise of valid and the matching ready.
`define TINY_MEM_WAIT 2

// First instruction address fetched after reset.
`define TINY_RESET_PC 0

// Number of general registers in the core.
`define TINY_NUM_REGS 16

`endif

// File: tiny_pkg.sv
`default_nettype none

package tiny_pkg;

    typedef logic [15:0] word_t;
    typedef logic [15:0] addr_t;
    typedef logic [3:0] reg_idx_t;
    typedef logic [7:0] imm8_t;
    typedef logic [3:0] imm4_t;

    // Codes 13 to 15 are illegal and stop the core with error set.
    typedef enum logic [3:0] {
        OP_LDI = 4'h0,
        OP_ADD = 4'h1,
        OP_SUB = 4'h2,
        OP_AND = 4'h3,
        OP_OR  = 4'h4,
        OP_XOR = 4'h5,
        OP_SHL = 4'h6,
        OP_MUL = 4'h7,
        OP_LD  = 4'h8,
        OP_ST  = 4'h9,
        OP_BR  = 4'ha,
        OP_NOP = 4'hb,
        OP_HLT = 4'hc
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SHL,
        ALU_MUL
    } alu_op_t;

    typedef struct packed {
        logic  write;
        addr_t addr;
        word_t wdata;
    } bus_req_t;

    // The imm8 field overlaps rs and imm4 in the instruction word.
    typedef struct packed {
        opcode_t  op;
        reg_idx_t rd;
        reg_idx_t rs;
        imm8_t    imm8;
        imm4_t    imm4;
    } decoded_t;

endpackage

`default_nettype wire

// File: tiny_alu.sv
`timescale 1ns/1ps
`default_nettype none

module tiny_alu (
    input  wire tiny_pkg::alu_op_t op,
    input  wire tiny_pkg::word_t   a,
    input  wire tiny_pkg::word_t   b,
    output tiny_pkg::word_t        result,
    output tiny_pkg::word_t        result_hi,
    output logic                   c,
    output logic                   z,
    output logic                   n
);

    logic [16:0] sum;
    logic [16:0] diff;
    logic [31:0] product;

    assign sum = {1'b0, a} + {1'b0, b};
    assign diff = {1'b0, a} + {1'b0, ~b} + 17'd1; // Bit 16 is the inverted borrow.
    assign product = {16'h0000, a} * {16'h0000, b};

    always_comb begin
        result = '0;
        result_hi = '0;
        c = 1'b0;
        case (op)
            tiny_pkg::ALU_ADD: begin
                result = sum[15:0];
                c = sum[16];
            end
            tiny_pkg::ALU_SUB: begin
                result = diff[15:0];
                c = diff[16];
            end
            tiny_pkg::ALU_AND: begin
                result = a & b;
            end
            tiny_pkg::ALU_OR: begin
                result = a | b;
            end
            tiny_pkg::ALU_XOR: begin
                result = a ^ b;
            end
            tiny_pkg::ALU_SHL: begin
                result = a << b[3:0];
            end
            tiny_pkg::ALU_MUL: begin
                result = product[15:0];
                result_hi = product[31:16];
            end
            default: begin
                result = sum[15:0];
            end
        endcase
    end

    assign z = (result == 16'h0000);
    assign n = result[15];

endmodule

`default_nettype wire

// File: tiny_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "tiny_cfg.svh"

module tiny_regfile (
    input  wire                     clk3Phase,
    input  wire                     reset,
    input  wire tiny_pkg::reg_idx_t rd_idx_a,
    input  wire tiny_pkg::reg_idx_t rd_idx_b,
    output tiny_pkg::word_t         rd_data_a,
    output tiny_pkg::word_t         rd_data_b,
    input  wire                     we_a,
    input  wire tiny_pkg::reg_idx_t wr_idx_a,
    input  wire tiny_pkg::word_t    wr_data_a,
    input  wire                     we_b,
    input  wire tiny_pkg::reg_idx_t wr_idx_b,
    input  wire tiny_pkg::word_t    wr_data_b
);

    tiny_pkg::word_t regs [`TINY_NUM_REGS];

    assign rd_data_a = regs[rd_idx_a];
    assign rd_data_b = regs[rd_idx_b];

    always_ff @(posedge clk3Phase) begin
        if (!reset) begin
            for (int i = 0; i < `TINY_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (we_a) begin
                regs[wr_idx_a] <= wr_data_a;
            end
            if (we_b) begin
                regs[wr_idx_b] <= wr_data_b; // Last write wins on a shared index.
            end
        end
    end

endmodule

`default_nettype wire

// File: tiny_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "tiny_cfg.svh"

module tiny_core (
    input  wire                  clk3Phase,
    input  wire                  reset,
    input  wire                  run,
    output logic                 req_valid,
    output tiny_pkg::bus_req_t   req,
    input  wire                  req_ready,
    input  wire tiny_pkg::word_t rdata,
    output logic                 halted,
    output logic                 error
);

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        DECODE,
        EXEC,
        MEM,
        HALT
    } state_t;

    state_t               state;
    tiny_pkg::addr_t      pc;
    tiny_pkg::decoded_t   dec;
    tiny_pkg::bus_req_t   mem_req;
    logic                 flag_c;
    logic                 flag_z;
    logic                 flag_n;
    tiny_pkg::word_t      rd_data;
    tiny_pkg::word_t      rs_data;
    tiny_pkg::word_t      imm8_ext;
    tiny_pkg::word_t      imm4_ext;
    tiny_pkg::alu_op_t    alu_op;
    tiny_pkg::word_t      alu_a;
    tiny_pkg::word_t      alu_b;
    tiny_pkg::word_t      alu_res;
    tiny_pkg::word_t      alu_res_hi;
    logic                 alu_c;
    logic                 alu_z;
    logic                 alu_n;
    logic                 is_alu;
    logic                 br_taken;
    logic                 accept;
    logic                 we_a;
    logic                 we_b;
    tiny_pkg::word_t      wr_data_a;

    assign imm8_ext = {{8{dec.imm8[7]}}, dec.imm8};
    assign imm4_ext = {{12{dec.imm4[3]}}, dec.imm4};

    // Bits 10 to 8 select c, z and n, and bit 11 inverts the test.
    assign br_taken = (|(dec.rd[2:0] & {flag_c, flag_z, flag_n})) ^ dec.rd[3];

    assign req_valid = (state == FETCH) || (state == MEM);
    assign accept = req_valid && req_ready;
    assign halted = (state == HALT);

    always_comb begin
        if (state == FETCH) begin
            req.write = 1'b0;
            req.addr = pc;
            req.wdata = '0;
        end else begin
            req = mem_req;
        end
    end

    always_comb begin
        is_alu = 1'b1;
        alu_op = tiny_pkg::ALU_ADD;
        case (dec.op)
            tiny_pkg::OP_ADD: alu_op = tiny_pkg::ALU_ADD;
            tiny_pkg::OP_SUB: alu_op = tiny_pkg::ALU_SUB;
            tiny_pkg::OP_AND: alu_op = tiny_pkg::ALU_AND;
            tiny_pkg::OP_OR:  alu_op = tiny_pkg::ALU_OR;
            tiny_pkg::OP_XOR: alu_op = tiny_pkg::ALU_XOR;
            tiny_pkg::OP_SHL: alu_op = tiny_pkg::ALU_SHL;
            tiny_pkg::OP_MUL: alu_op = tiny_pkg::ALU_MUL;
            default:          is_alu = 1'b0;
        endcase
    end

    assign alu_a = (dec.op == tiny_pkg::OP_SHL) ? rs_data : rd_data;
    assign alu_b = (dec.op == tiny_pkg::OP_SHL) ? {12'h000, dec.imm4} : rs_data;

    assign we_a = ((state == EXEC) && (is_alu || dec.op == tiny_pkg::OP_LDI))
               || ((state == MEM) && accept && dec.op == tiny_pkg::OP_LD);
    assign we_b = (state == EXEC) && (dec.op == tiny_pkg::OP_MUL);

    always_comb begin
        if (state == MEM) begin
            wr_data_a = rdata;
        end else if (dec.op == tiny_pkg::OP_LDI) begin
            wr_data_a = imm8_ext;
        end else begin
            wr_data_a = alu_res;
        end
    end

    tiny_alu u_alu (
        .op        (alu_op),
        .a         (alu_a),
        .b         (alu_b),
        .result    (alu_res),
        .result_hi (alu_res_hi),
        .c         (alu_c),
        .z         (alu_z),
        .n         (alu_n)
    );

    tiny_regfile u_regfile (
        .clk3Phase (clk3Phase),
        .reset     (reset),
        .rd_idx_a  (dec.rd),
        .rd_idx_b  (dec.rs),
        .rd_data_a (rd_data),
        .rd_data_b (rs_data),
        .we_a      (we_a),
        .wr_idx_a  (dec.rd),
        .wr_data_a (wr_data_a),
        .we_b      (we_b),
        .wr_idx_b  (dec.rd + 4'd1),
        .wr_data_b (alu_res_hi)
    );

    always_ff @(posedge clk3Phase) begin
        if (!reset) begin
            state <= IDLE;
            pc <= tiny_pkg::addr_t'(`TINY_RESET_PC);
            flag_c <= 1'b0;
            flag_z <= 1'b0;
            flag_n <= 1'b0;
            error <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (run) begin
                        state <= FETCH;
                    end
                end
                FETCH: begin
                    if (accept) begin
                        state <= DECODE;
                    end
                end
                DECODE: begin
                    state <= EXEC;
                end
                EXEC: begin
                    if (dec.op == tiny_pkg::OP_BR && br_taken) begin
                        pc <= pc + 16'd1 + imm8_ext;
                    end else begin
                        pc <= pc + 16'd1;
                    end
                    if (is_alu) begin
                        flag_c <= alu_c;
                        flag_z <= alu_z;
                        flag_n <= alu_n;
                    end else if (dec.op == tiny_pkg::OP_LDI) begin
                        flag_z <= (imm8_ext == 16'h0000); // Carry keeps its old value.
                        flag_n <= imm8_ext[15];
                    end
                    case (dec.op)
                        tiny_pkg::OP_LD, tiny_pkg::OP_ST: begin
                            state <= MEM;
                        end
                        tiny_pkg::OP_HLT: begin
                            state <= HALT;
                        end
                        tiny_pkg::OP_LDI, tiny_pkg::OP_ADD, tiny_pkg::OP_SUB,
                        tiny_pkg::OP_AND, tiny_pkg::OP_OR, tiny_pkg::OP_XOR,
                        tiny_pkg::OP_SHL, tiny_pkg::OP_MUL, tiny_pkg::OP_BR,
                        tiny_pkg::OP_NOP: begin
                            state <= run ? FETCH : IDLE;
                        end
                        default: begin
                            state <= HALT;
                            error <= 1'b1;
                        end
                    endcase
                end
                MEM: begin
                    if (accept) begin
                        state <= run ? FETCH : IDLE;
                    end
                end
                HALT: begin
                    state <= HALT; // Only reset leaves this state.
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk3Phase) begin
        if (state == FETCH && accept) begin
            dec <= '{op:   tiny_pkg::opcode_t'(rdata[15:12]),
                     rd:   rdata[11:8],
                     rs:   rdata[7:4],
                     imm8: rdata[7:0],
                     imm4: rdata[3:0]};
        end
        if (state == DECODE) begin
            mem_req.write <= (dec.op == tiny_pkg::OP_ST);
            if (dec.op == tiny_pkg::OP_ST) begin
                mem_req.addr <= rd_data + imm4_ext;
            end else begin
                mem_req.addr <= rs_data + imm4_ext;
            end
            mem_req.wdata <= rs_data;
        end
    end

endmodule

`default_nettype wire

// File: tiny_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "tiny_cfg.svh"

module tiny_mem (
    input  wire                    clk3Phase,
    input  wire                    reset,
    input  wire                    run,
    input  wire                    core_valid,
    input  wire tiny_pkg::bus_req_t core_req,
    output logic                   core_ready,
    input  wire                    host_valid,
    input  wire                    host_write,
    input  wire tiny_pkg::addr_t   host_addr,
    input  wire tiny_pkg::word_t   host_wdata,
    output logic                   host_ready,
    output tiny_pkg::word_t        rdata
);

    localparam int WORDS = `TINY_MEM_WORDS;
    localparam int WAIT = `TINY_MEM_WAIT;
    localparam int AW = $clog2(WORDS);
    localparam int CW = $clog2(WAIT + 2);

    tiny_pkg::word_t    mem [WORDS];
    tiny_pkg::bus_req_t sel_req;
    logic               sel_valid;
    logic               sel_ready;
    logic [CW-1:0]      wait_cnt;
    logic [AW-1:0]      idx;

    // The core owns the port while running, the host while stopped.
    always_comb begin
        if (run) begin
            sel_valid = core_valid;
            sel_req = core_req;
        end else begin
            sel_valid = host_valid;
            sel_req.write = host_write;
            sel_req.addr = host_addr;
            sel_req.wdata = host_wdata;
        end
    end

    assign idx = sel_req.addr[AW-1:0];
    assign sel_ready = sel_valid && (wait_cnt == CW'(WAIT));
    assign core_ready = run && sel_ready;
    assign host_ready = !run && sel_ready;
    assign rdata = mem[idx];

    always_ff @(posedge clk3Phase) begin
        if (!reset) begin
            wait_cnt <= '0;
        end else if (!sel_valid || sel_ready) begin
            wait_cnt <= '0; // Each accepted request starts a fresh count.
        end else begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk3Phase) begin
        if (sel_ready && sel_req.write) begin
            mem[idx] <= sel_req.wdata;
        end
    end

endmodule

`default_nettype wire

// File: tiny_system.sv
`timescale 1ns/1ps
`default_nettype none

module tiny_system (
    input  wire                  clk3Phase,
    input  wire                  reset,
    input  wire                  run,
    input  wire                  host_valid,
    input  wire                  host_write,
    input  wire tiny_pkg::addr_t host_addr,
    input  wire tiny_pkg::word_t host_wdata,
    output logic                 host_ready,
    output tiny_pkg::word_t      host_rdata,
    output logic                 halted,
    output logic                 error
);

    logic               core_valid;
    logic               core_ready;
    tiny_pkg::bus_req_t core_req;
    tiny_pkg::word_t    mem_rdata;

    tiny_core u_core (
        .clk3Phase (clk3Phase),
        .reset     (reset),
        .run       (run),
        .req_valid (core_valid),
        .req       (core_req),
        .req_ready (core_ready),
        .rdata     (mem_rdata),
        .halted    (halted),
        .error     (error)
    );

    tiny_mem u_mem (
        .clk3Phase  (clk3Phase),
        .reset      (reset),
        .run        (run),
        .core_valid (core_valid),
        .core_req   (core_req),
        .core_ready (core_ready),
        .host_valid (host_valid),
        .host_write (host_write),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_ready (host_ready),
        .rdata      (mem_rdata)
    );

    assign host_rdata = mem_rdata; // Core and host share the read data path.

endmodule

`default_nettype wire

// File: tiny_system_assert.sv
`timescale 1ns/1ps
`default_nettype none

`include "tiny_cfg.svh"

module tiny_system_assert (
    input wire                     clk3Phase,
    input wire                     reset,
    input wire                     run,
    input wire                     core_valid,
    input wire tiny_pkg::bus_req_t core_req,
    input wire                     core_ready,
    input wire                     host_valid,
    input wire                     host_write,
    input wire tiny_pkg::addr_t    host_addr,
    input wire tiny_pkg::word_t    host_wdata,
    input wire                     host_ready
);

    // A core request waiting for ready keeps valid and its payload.
    core_req_held: assert property (@(posedge clk3Phase) disable iff (!reset)
        (core_valid && !core_ready) |=> (core_valid && $stable(core_req)))
        else $error("core request changed before it was accepted");

    host_req_held: assert property (@(posedge clk3Phase) disable iff (!reset)
        (!run && host_valid && !host_ready)
        |=> (host_valid && $stable({host_write, host_addr, host_wdata})))
        else $error("host request changed before it was accepted");

    // Ready comes with valid, after the request has waited through the wait states.
    core_ready_after_wait: assert property (@(posedge clk3Phase) disable iff (!reset)
        core_ready |-> (core_valid && $past(core_valid && !core_ready, `TINY_MEM_WAIT)))
        else $error("core ready raised without a request waiting through the wait states");

    host_ready_after_wait: assert property (@(posedge clk3Phase) disable iff (!reset)
        host_ready |-> (host_valid && $past(host_valid && !host_ready, `TINY_MEM_WAIT)))
        else $error("host ready raised without a request waiting through the wait states");

    core_quiet_when_stopped: assert property (@(posedge clk3Phase) disable iff (!reset)
        !run |-> !core_valid)
        else $error("core accessed memory while run was low");

endmodule

bind tiny_mem tiny_system_assert u_mem_assert (
    .clk3Phase  (clk3Phase),
    .reset      (reset),
    .run        (run),
    .core_valid (core_valid),
    .core_req   (core_req),
    .core_ready (core_ready),
    .host_valid (host_valid),
    .host_write (host_write),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .host_ready (host_ready)
);

`default_nettype wire

// File: tb_tiny_system.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tiny_system;

    // Host transfers plus executed instructions of each test, in test order.
    localparam int TEST_STEPS = 40 + 60 + 25 + 25 + 80 + 30;
    localparam int TIMEOUT_CYCLES = TEST_STEPS * 8 * 2;

    logic            clk3Phase;
    logic            reset;
    logic            run;
    logic            host_valid;
    logic            host_write;
    tiny_pkg::addr_t host_addr;
    tiny_pkg::word_t host_wdata;
    logic            host_ready;
    tiny_pkg::word_t host_rdata;
    logic            halted;
    logic            error;

    tiny_pkg::word_t prog [$];
    logic [31:0]     rng_state = 32'ha2bf_9f75;
    int              cycle_count = 0;

    tiny_system u_tiny_system (
        .clk3Phase  (clk3Phase),
        .reset      (reset),
        .run        (run),
        .host_valid (host_valid),
        .host_write (host_write),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_ready (host_ready),
        .host_rdata (host_rdata),
        .halted     (halted),
        .error      (error)
    );

    always #10 clk3Phase = ~clk3Phase;

    always @(posedge clk3Phase) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("timeout: no result after %0d cycles", cycle_count);
            $display("Simulation FAILED");
            $fatal(1, "cycle limit reached");
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        return s ^ (s << 5);
    endfunction

    function logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic tiny_pkg::word_t instr_reg(input logic [3:0] op, input logic [3:0] rd,
                                                  input logic [3:0] rs, input logic [3:0] imm4);
        return {op, rd, rs, imm4};
    endfunction

    function automatic tiny_pkg::word_t instr_imm(input logic [3:0] op, input logic [3:0] rd,
                                                  input logic [7:0] imm8);
        return {op, rd, imm8};
    endfunction

    function automatic tiny_pkg::word_t sext4(input logic [3:0] v);
        return {{12{v[3]}}, v};
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "stopped at the first failed check");
    endtask

    task automatic apply_reset();
        @(posedge clk3Phase);
        reset <= 1'b0;
        repeat (8) @(posedge clk3Phase);
        reset <= 1'b1;
    endtask

    task automatic write_word(input tiny_pkg::addr_t addr, input tiny_pkg::word_t data);
        @(posedge clk3Phase);
        host_valid <= 1'b1;
        host_write <= 1'b1;
        host_addr <= addr;
        host_wdata <= data;
        do begin
            @(negedge clk3Phase);
        end while (!host_ready);
        @(posedge clk3Phase);
        host_valid <= 1'b0;
        host_write <= 1'b0;
    endtask

    task automatic read_word(input tiny_pkg::addr_t addr, output tiny_pkg::word_t data);
        @(posedge clk3Phase);
        host_valid <= 1'b1;
        host_write <= 1'b0;
        host_addr <= addr;
        do begin
            @(negedge clk3Phase);
        end while (!host_ready);
        data = host_rdata; // Read data is valid in the accept cycle.
        @(posedge clk3Phase);
        host_valid <= 1'b0;
    endtask

    task automatic check_word(input tiny_pkg::addr_t addr, input tiny_pkg::word_t exp,
                              input string what);
        tiny_pkg::word_t got;
        read_word(addr, got);
        assert (got === exp) else begin
            report_failure($sformatf("mismatch at %0d ns: %s at address %h, got %h, expected %h",
                                     $time, what, addr, got, exp));
        end
    endtask

    // Loads prog from address 0, runs the core until it halts, and hands the bus back.
    task automatic run_program(output logic err_at_halt);
        for (int i = 0; i < prog.size(); i++) begin
            write_word(16'(i), prog[i]);
        end
        @(negedge clk3Phase);
        assert (!halted) else report_failure("core halted while run was low");
        @(posedge clk3Phase);
        run <= 1'b1;
        do begin
            @(negedge clk3Phase);
            assert (!(error && !halted)) else report_failure("error rose before halted");
        end while (!halted);
        err_at_halt = error;
        @(posedge clk3Phase);
        run <= 1'b0;
    endtask

    task automatic test_host_port();
        tiny_pkg::word_t data [16];
        tiny_pkg::word_t wrap_data;
        for (int i = 0; i < 16; i++) begin
            data[i] = 16'(next_random());
            write_word(16'h0080 + 16'(i), data[i]);
        end
        wrap_data = 16'(next_random());
        write_word(16'h01a5, wrap_data); // Lands on word 0xa5 of the 256-word memory.
        for (int i = 0; i < 16; i++) begin
            check_word(16'h0080 + 16'(i), data[i], "host read-back");
        end
        check_word(16'h00a5, wrap_data, "wrapped host address");
        @(negedge clk3Phase);
        assert (!halted && !error) else report_failure("halted or error set while run is low");
    endtask

    task automatic test_alu_ops();
        tiny_pkg::word_t a;
        tiny_pkg::word_t b;
        logic [7:0]      imm;
        logic [3:0]      sh;
        logic            err;
        logic [3:0]      ops [5];
        tiny_pkg::word_t exp_val [5];
        a = 16'(next_random());
        b = 16'(next_random());
        imm = 8'(next_random());
        sh = 4'(next_random());
        ops = '{tiny_pkg::OP_ADD, tiny_pkg::OP_SUB, tiny_pkg::OP_AND, tiny_pkg::OP_OR,
                tiny_pkg::OP_XOR};
        exp_val = '{a + b, a - b, a & b, a | b, a ^ b};
        apply_reset();
        write_word(16'h0040, a);
        write_word(16'h0041, b);
        prog.delete();
        prog.push_back(instr_imm(tiny_pkg::OP_LDI, 4'd15, 8'h40));
        prog.push_back(instr_imm(tiny_pkg::OP_LDI, 4'd14, 8'h60));
        prog.push_back(instr_reg(tiny_pkg::OP_LD, 4'd2, 4'd15, 4'd1));
        prog.push_back(instr_imm(tiny_pkg::OP_LDI, 4'd3, imm));
        prog.push_back(instr_reg(tiny_pkg::OP_ST, 4'd14, 4'd3, 4'h8));
        for (int k = 0; k < 5; k++) begin
            prog.push_back(instr_reg(tiny_pkg::OP_LD, 4'd4, 4'd15, 4'd0));
            prog.push_back(instr_reg(ops[k], 4'd4, 4'd2, 4'd0));
            prog.push_back(instr_reg(tiny_pkg::OP_ST, 4'd14, 4'd4, 4'(k)));
        end
        prog.push_back(instr_reg(tiny_pkg::OP_LD, 4'd1, 4'd15, 4'd0));
        prog.push_back(instr_reg(tiny_pkg::OP_SHL, 4'd5, 4'd1, sh));
        prog.push_back(instr_reg(tiny_pkg::OP_ST, 4'd14, 4'd5, 4'd5));
        prog.push_back(instr_reg(tiny_pkg::OP_HLT, 4'd0, 4'd0, 4'd0));
        run_program(err);
        assert (!err) else report_failure("error output set by a legal program");
        check_word(16'h0058, {{8{imm[7]}}, imm}, "LDI immediate");
        for (int k = 0; k < 5; k++) begin
            check_word(16'h0060 + 16'(k), exp_val[k], "ALU result");
        end
        check_word(16'h0065, a << sh, "SHL result");
    endtask

    task automatic test_multiply();
        tiny_pkg::word_t x;
        tiny_pkg::word_t y;
        logic [31:0]     product;
        logic            err;
        x = 16'(next_random());
        y = 16'(next_random());
        product = '0;
        for (int i = 0; i < 16; i++) begin
            if (y[i]) begin
                product = product + ({16'h0000, x} << i); // Shift-and-add over the bits of y.
            end
        end
        apply_reset();
        write_word(16'h0042, x);
        write_word(16'h0043, y);
        prog.delete();
        prog.push_back(instr_imm(tiny_pkg::OP_LDI, 4'd15, 8'h40));
        prog.push_back(instr_imm(tiny_pkg::OP_LDI, 4'd14, 8'h60));
        prog.push_back(instr_reg(tiny_pkg::OP_LD, 4'd6, 4'd15, 4'd2));
        prog.push_back(instr_reg(tiny_pkg::OP_LD, 4'd7, 4'd15, 4'd3));
        prog.push_back(instr_reg(tiny_pkg::OP_MUL, 4'd6, 4'd7, 4'd0));
        prog.push_back(instr_reg(tiny_pkg::OP_ST, 4'd14, 4'd6, 4'd6));
        prog.push_back(instr_reg(tiny_pkg::OP_ST, 4'd14, 4'd7, 4'd7));
        prog.push_back(instr_reg(tiny_pkg::OP_HLT, 4'd0, 4'd0, 4'd0));
        run_program(err);
        assert (!err) else report_failure("error output set by a legal program");
        check_word(16'h0066, product[15:0], "product low word");
        check_word(16'h0067, product[31:16], "product high word");
    endtask

    task automatic test_load_store();
        tiny_pkg::word_t v1;
        tiny_pkg::word_t v2;
        logic            err;
        v1 = 16'(next_random());
        v2 = 16'(next_random());
        apply_reset();
        write_word(16'h0048 + sext4(4'h8), ~v2);
        write_word(16'h0048 + sext4(4'h5), ~v1);
        write_word(16'h0048 + sext4(4'hd), v1);
        write_word(16'h0048 + sext4(4'h7), v2);
        prog.delete();
        prog.push_back(instr_imm(tiny_pkg::OP_LDI, 4'd15, 8'h48));
        prog.push_back(instr_reg(tiny_pkg::OP_LD, 4'd1, 4'd15, 4'hd));
        prog.push_back(instr_reg(tiny_pkg::OP_LD, 4'd2, 4'd15, 4'h7));
        prog.push_back(instr_reg(tiny_pkg::OP_ST, 4'd15, 4'd2, 4'h8));
        prog.push_back(instr_reg(tiny_pkg::OP_ST, 4'd15, 4'd1, 4'h5));
        prog.push_back(instr_reg(tiny_pkg::OP_HLT, 4'd0, 4'd0, 4'd0));
        run_program(err);
        assert (!err) else report_failure("error output set by a legal program");
        check_word(16'h0048 + sext4(4'h8), v2, "store at negative offset");
        check_word(16'h0048 + sext4(4'h5), v1, "store at positive offset");
        check_word(16'h0048 + sext4(4'hd), v1, "load source");
    endtask

    task automatic test_branches();
        logic [7:0]      count;
        tiny_pkg::word_t exp_counter;
        tiny_pkg::word_t exp_iters;
        logic            err;
        count = 8'(1 + (next_random() % 15));
        exp_counter = 16'(count);
        exp_iters = '0;
        do begin
            exp_iters = exp_iters + 16'd1;
            exp_counter = exp_counter - 16'd1;
        end while (exp_counter != 16'h0000);
        apply_reset();
        for (int i = 0; i < 4; i++) begin
            write_word(16'h0060 + 16'(i), 16'hbad0 + 16'(i));
        end
        prog.delete();
        prog.push_back(instr_imm(tiny_pkg::OP_LDI, 4'd15, 8'h60));
        prog.push_back(instr_imm(tiny_pkg::OP_LDI, 4'd1, count));
        prog.push_back(instr_imm(tiny_pkg::OP_LDI, 4'd2, 8'h00));
        prog.push_back(instr_imm(tiny_pkg::OP_LDI, 4'd3, 8'h01));
        prog.push_back(instr_reg(tiny_pkg::OP_ADD, 4'd2, 4'd3, 4'd0));
        prog.push_back(instr_reg(tiny_pkg::OP_SUB, 4'd1, 4'd3, 4'd0));
        prog.push_back(instr_imm(tiny_pkg::OP_BR, 4'b1010, 8'hfd)); // Loop back while z is clear.
        prog.push_back(instr_imm(tiny_pkg::OP_BR, 4'b0001, 8'h01));
        prog.push_back(instr_reg(tiny_pkg::OP_ST, 4'd15, 4'd3, 4'd2));
        prog.push_back(instr_reg(tiny_pkg::OP_ST, 4'd15, 4'd1, 4'd0));
        prog.push_back(instr_reg(tiny_pkg::OP_ST, 4'd15, 4'd2, 4'd1));
        prog.push_back(instr_imm(tiny_pkg::OP_BR, 4'b0010, 8'h01));
        prog.push_back(instr_reg(tiny_pkg::OP_ST, 4'd15, 4'd2, 4'd3));
        prog.push_back(instr_reg(tiny_pkg::OP_HLT, 4'd0, 4'd0, 4'd0));
        run_program(err);
        assert (!err) else report_failure("error output set by a legal program");
        check_word(16'h0060, exp_counter, "final loop counter");
        check_word(16'h0061, exp_iters, "loop iteration count");
        check_word(16'h0062, 16'h0001, "fall-through marker");
        check_word(16'h0063, 16'hbad3, "store skipped by taken branch");
    endtask

    task automatic test_illegal_opcode();
        logic [3:0] bad_op;
        logic       err;
        bad_op = 4'hd + 4'(next_random() % 3);
        apply_reset();
        write_word(16'h0064, 16'hbad4);
        write_word(16'h0065, 16'hbad5);
        prog.delete();
        prog.push_back(instr_imm(tiny_pkg::OP_LDI, 4'd15, 8'h60));
        prog.push_back(instr_imm(tiny_pkg::OP_LDI, 4'd1, 8'h2b));
        prog.push_back(instr_reg(tiny_pkg::OP_ST, 4'd15, 4'd1, 4'd4));
        prog.push_back(instr_reg(bad_op, 4'd0, 4'd0, 4'd0));
        prog.push_back(instr_reg(tiny_pkg::OP_ST, 4'd15, 4'd1, 4'd5));
        prog.push_back(instr_reg(tiny_pkg::OP_HLT, 4'd0, 4'd0, 4'd0));
        run_program(err);
        assert (err) else report_failure("illegal opcode did not raise error with halted");
        check_word(16'h0064, 16'h002b, "store before illegal opcode");
        check_word(16'h0065, 16'hbad5, "store after illegal opcode");
        @(negedge clk3Phase);
        assert (halted && error) else report_failure("halted or error dropped before reset");
    endtask

    initial begin
        clk3Phase = 1'b0;
        reset = 1'b0;
        run = 1'b0;
        host_valid = 1'b0;
        host_write = 1'b0;
        host_addr = '0;
        host_wdata = '0;
        repeat (8) @(posedge clk3Phase);
        reset <= 1'b1;
        test_host_port();
        test_alu_ops();
        test_multiply();
        test_load_store();
        test_branches();
        test_illegal_opcode();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+.
tiny_pkg.sv
tiny_alu.sv
tiny_regfile.sv
tiny_core.sv
tiny_mem.sv
tiny_system.sv
tiny_system_assert.sv
tb_tiny_system.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_tiny_system -f all.f -o sim_tiny_system
if [ $? -ne 0 ]; then
    echo "run_sim: compile step failed"
    exit 1
fi

./obj_dir/sim_tiny_system > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "run_sim: simulation exited with status $run_status"
    exit 1
fi

if grep -q "Simulation PASSED" "$LOG"; then
    echo "run_sim: pass"
    exit 0
else
    echo "run_sim: fail"
    exit 1
fi
